// File: all.f
verilog/simt_pkg.sv
verilog/isa_pkg.sv
verilog/lane_alu.sv
verilog/csr_unit.sv
verilog/load_unit.sv
verilog/writeback_arbiter.sv
verilog/warp_gpr.sv
verilog/simt_wb_top.sv
verif/tb_simt_wb.sv

// File: Makefile
# Verilator simulation of the SIMT writeback subsystem

VERILATOR ?= verilator
TOP ?= tb_simt_wb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/10ps -j 0

SRCS := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_simt_wb.sv
`timescale 1ns/10ps
`default_nettype none

module tb_simt_wb
	import simt_pkg::*;
	import isa_pkg::*;
();

	localparam int nt = 4;
	localparam int nw = 4;
	localparam int ww = 2;
	localparam int n_instr = 300;
	localparam int cycle_limit = 8 * n_instr + 200;

	typedef struct packed {
		wb_src_t src;
		logic [ww-1:0] warp;
		logic [reg_w-1:0] rd;
		logic [nt-1:0] mask;
		logic [data_w-1:0] pc;
		logic [nt-1:0][data_w-1:0] data;
	} wb_rec_t;

	logic clk;
	logic reset;
	logic issue_valid;
	unit_t issue_unit;
	alu_op_t issue_alu_op;
	csr_op_t issue_csr_op;
	logic [ww-1:0] issue_warp;
	logic [reg_w-1:0] issue_rd;
	logic [nt-1:0] issue_mask;
	logic [data_w-1:0] issue_pc;
	logic [nt-1:0][data_w-1:0] issue_a;
	logic [nt-1:0][data_w-1:0] issue_b;
	logic issue_ready;
	logic psel;
	logic penable;
	logic pwrite;
	logic [data_w-1:0] paddr;
	logic [data_w-1:0] prdata;
	logic pready;
	wb_src_t wb_src;
	logic [nt-1:0] wb_mask;
	logic [reg_w-1:0] wb_rd;
	logic [ww-1:0] wb_warp;
	logic [data_w-1:0] wb_pc;
	logic [nt-1:0][data_w-1:0] wb_data;
	logic [ww-1:0] gpr_rd_warp;
	logic [reg_w-1:0] gpr_rd_reg;
	logic [nt-1:0][data_w-1:0] gpr_rd_data;

	integer seed;
	int cycles = 0;
	int issued = 0;
	int stalls = 0;
	int apb_wait = 0;
	logic taken;
	logic done;
	wb_rec_t st1;  // alu/csr result one cycle behind issue
	wb_rec_t st2;  // due on the wb outputs this cycle
	wb_rec_t load_q[$];
	logic [data_w-1:0] shadow [nw][reg_n][nt];
	logic [data_w-1:0] scratch_m [nw];

	simt_wb_top #(.nt(nt), .nw(nw)) dut (
		.clk(clk), .reset(reset),
		.issue_valid(issue_valid), .issue_unit(issue_unit),
		.issue_alu_op(issue_alu_op), .issue_csr_op(issue_csr_op),
		.issue_warp(issue_warp), .issue_rd(issue_rd), .issue_mask(issue_mask),
		.issue_pc(issue_pc), .issue_a(issue_a), .issue_b(issue_b),
		.issue_ready(issue_ready),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.prdata(prdata), .pready(pready),
		.wb_src(wb_src), .wb_mask(wb_mask), .wb_rd(wb_rd),
		.wb_warp(wb_warp), .wb_pc(wb_pc), .wb_data(wb_data),
		.gpr_rd_warp(gpr_rd_warp), .gpr_rd_reg(gpr_rd_reg), .gpr_rd_data(gpr_rd_data)
	);

	always #20 clk = ~clk;

	task automatic abort_run;
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_src(input wb_src_t got, input wb_src_t exp);
		if (got !== exp) begin
			$display("error at %0t: wb_src expected %s got %s", $time, exp.name(), got.name());
			abort_run();
		end
	endtask

	task automatic check_data(input string name, input logic [data_w-1:0] got,
			input logic [data_w-1:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t: %s expected %b got %b", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_gpr(input int w, input int r, input int lane,
			input logic [data_w-1:0] got, input logic [data_w-1:0] exp);
		if (got !== exp) begin
			$display("error at %0t: gpr_rd_data[%0d] of warp %0d reg %0d expected %h got %h",
				$time, lane, w, r, exp, got);
			abort_run();
		end
	endtask

	function automatic logic [data_w-1:0] alu_ref(input alu_op_t op,
			input logic [data_w-1:0] a, input logic [data_w-1:0] b);
		case (op)
			op_add: return a + b;
			op_sub: return a - b;
			op_and: return a & b;
			op_or: return a | b;
			op_xor: return a ^ b;
			op_sll: return a << b[4:0];
			op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	task automatic drive_random_instr;
		int pick;
		pick = {$random(seed)} % 8;
		issue_valid = (pick != 0);  // an idle slot now and then
		pick = {$random(seed)} % 8;
		if (pick < 2)
			issue_unit = unit_csr;
		else if (pick < 4 && (load_q.size() == 0 || {$random(seed)} % 4 == 0))
			issue_unit = unit_load;  // a second load stays rare
		else
			issue_unit = unit_alu;
		issue_alu_op = alu_op_t'(3'({$random(seed)} % 7));
		issue_csr_op = ({$random(seed)} % 2 == 0) ? csr_swap_scratch : csr_read_id;
		issue_warp = ww'($random(seed));
		issue_rd = ({$random(seed)} % 8 == 0) ? '0 : reg_w'($random(seed));
		issue_mask = nt'($random(seed));
		issue_pc = $random(seed);
		for (int i = 0; i < nt; i++) begin
			issue_a[i] = $random(seed);
			issue_b[i] = $random(seed);
		end
	endtask

	// expected writeback of the instruction taken at the coming edge
	task automatic record_issue;
		wb_rec_t rec;
		logic found;
		rec = '0;
		found = 1'b0;
		rec.warp = issue_warp;
		rec.rd = issue_rd;
		rec.mask = issue_mask;
		rec.pc = issue_pc;
		case (issue_unit)
			unit_alu: begin
				rec.src = wb_alu;
				for (int i = 0; i < nt; i++)
					rec.data[i] = alu_ref(issue_alu_op, issue_a[i], issue_b[i]);
			end
			unit_csr: begin
				rec.src = wb_csr;
				rec.pc = 32'hdeadbeef;
				for (int i = 0; i < nt; i++) begin
					if (issue_csr_op == csr_read_id)
						rec.data[i] = 32'(issue_warp) * 256 + 32'(i);
					else
						rec.data[i] = scratch_m[issue_warp];
				end
				if (issue_csr_op == csr_swap_scratch) begin
					for (int i = 0; i < nt; i++) begin
						if (issue_mask[i] && !found) begin
							scratch_m[issue_warp] = issue_a[i];  // lowest active lane
							found = 1'b1;
						end
					end
				end
			end
			default: begin
				rec.src = wb_mem;
				for (int i = 0; i < nt; i++)
					rec.data[i] = issue_mask[i] ? (issue_a[i] ^ 32'h5a5a0000) : '0;
			end
		endcase
		if (issue_rd != '0 && issue_mask != '0) begin
			if (rec.src == wb_mem)
				load_q.push_back(rec);
			else
				st1 = rec;
		end
	endtask

	task automatic check_writeback;
		wb_rec_t exp;
		if (st2.src != wb_none)
			exp = st2;
		else if (wb_src == wb_mem && load_q.size() != 0)
			exp = load_q.pop_front();
		else
			exp = '0;
		check_src(wb_src, exp.src);
		if (exp.src != wb_none) begin
			check_data("wb_pc", wb_pc, exp.pc);
			check_data("wb_rd", data_w'(wb_rd), data_w'(exp.rd));
			check_data("wb_warp", data_w'(wb_warp), data_w'(exp.warp));
			check_data("wb_mask", data_w'(wb_mask), data_w'(exp.mask));
			for (int i = 0; i < nt; i++) begin
				if (exp.mask[i] || exp.src == wb_mem)
					check_data($sformatf("wb_data[%0d]", i), wb_data[i], exp.data[i]);
				if (exp.mask[i])
					shadow[exp.warp][exp.rd][i] = exp.data[i];
			end
		end
	endtask

	// apb slave with 0 to 3 wait states per transfer
	always @(posedge clk) begin
		#1;
		if (psel)
			check_flag("pwrite", pwrite, 1'b0);
		if (psel && penable) begin
			if (apb_wait == 0) begin
				pready = 1'b1;
				prdata = paddr ^ 32'h5a5a0000;
			end else begin
				apb_wait = apb_wait - 1;
				pready = 1'b0;
			end
		end else begin
			pready = 1'b0;
			prdata = '0;
			apb_wait = {$random(seed)} % 4;
		end
	end

	always @(negedge clk) begin
		if (reset) begin
			taken = 1'b0;
		end else begin
			check_writeback();
			st2 = st1;
			st1 = '0;
			if (issue_valid && issue_unit != unit_load)
				check_flag("issue_ready", issue_ready, 1'b1);
			if (issue_valid && issue_unit == unit_load && load_q.size() != 0) begin
				check_flag("issue_ready", issue_ready, 1'b0);
				stalls = stalls + 1;
			end
			taken = issue_valid && issue_ready;
			if (taken) begin
				issued = issued + 1;
				record_issue();
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout, the run did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	initial begin
		seed = 43;
		clk = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_unit = unit_load;  // ready must still be high with the load unit idle
		issue_alu_op = op_add;
		issue_csr_op = csr_swap_scratch;
		issue_warp = '0;
		issue_rd = '0;
		issue_mask = '0;
		issue_pc = '0;
		issue_a = '0;
		issue_b = '0;
		prdata = '0;
		pready = 1'b0;
		gpr_rd_warp = '0;
		gpr_rd_reg = '0;
		taken = 1'b0;
		done = 1'b0;
		st1 = '0;
		st2 = '0;
		for (int w = 0; w < nw; w++) begin
			scratch_m[w] = '0;
			for (int r = 0; r < reg_n; r++) begin
				for (int i = 0; i < nt; i++)
					shadow[w][r][i] = '0;
			end
		end

		repeat (8) @(posedge clk);
		#1;
		check_src(wb_src, wb_none);
		check_flag("psel", psel, 1'b0);
		check_flag("penable", penable, 1'b0);
		check_flag("issue_ready", issue_ready, 1'b1);
		reset = 1'b0;

		while (!done) begin
			@(posedge clk);
			#1;
			if (!issue_valid || taken) begin  // a refused instruction is held
				if (issued == n_instr) begin
					issue_valid = 1'b0;
					done = 1'b1;
				end else begin
					drive_random_instr();
				end
			end
		end

		while (load_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);

		for (int w = 0; w < nw; w++) begin
			for (int r = 0; r < reg_n; r++) begin
				@(posedge clk);
				#1;
				gpr_rd_warp = ww'(w);
				gpr_rd_reg = reg_w'(r);
				@(negedge clk);
				for (int i = 0; i < nt; i++)
					check_gpr(w, r, i, gpr_rd_data[i], shadow[w][r][i]);
			end
		end

		if (stalls == 0) begin
			$display("no load was ever held back by a busy load unit");
			abort_run();
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog/simt_wb_top.sv
`timescale 1ns/10ps
`default_nettype none

module simt_wb_top import simt_pkg::*; import isa_pkg::*; #(
	parameter int nt = 4,
	parameter int nw = 4,
	localparam int ww = (nw > 1) ? $clog2(nw) : 1
) (
	input wire clk,
	input wire reset,
	input wire issue_valid,
	input wire unit_t issue_unit,
	input wire alu_op_t issue_alu_op,
	input wire csr_op_t issue_csr_op,
	input wire [ww-1:0] issue_warp,
	input wire [reg_w-1:0] issue_rd,
	input wire [nt-1:0] issue_mask,
	input wire [data_w-1:0] issue_pc,
	input wire [nt-1:0][data_w-1:0] issue_a,
	input wire [nt-1:0][data_w-1:0] issue_b,
	output logic issue_ready,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [data_w-1:0] paddr,
	input wire [data_w-1:0] prdata,
	input wire pready,
	output wb_src_t wb_src,
	output logic [nt-1:0] wb_mask,
	output logic [reg_w-1:0] wb_rd,
	output logic [ww-1:0] wb_warp,
	output logic [data_w-1:0] wb_pc,
	output logic [nt-1:0][data_w-1:0] wb_data,
	input wire [ww-1:0] gpr_rd_warp,
	input wire [reg_w-1:0] gpr_rd_reg,
	output logic [nt-1:0][data_w-1:0] gpr_rd_data
);

	logic issue_fire;
	logic load_busy;
	logic mem_taken;

	wb_src_t alu_wb, csr_wb, mem_wb;
	logic [nt-1:0] alu_mask, csr_mask, mem_mask;
	logic [reg_w-1:0] alu_rd, csr_rd, mem_rd;
	logic [ww-1:0] alu_warp, csr_warp, mem_warp;
	logic [data_w-1:0] alu_pc, mem_pc;
	logic [nt-1:0][data_w-1:0] alu_data, csr_data, mem_data;

	// only a second load has to wait
	assign issue_ready = !(load_busy && issue_unit == unit_load);
	assign issue_fire = issue_valid && issue_ready;

	lane_alu #(.nt(nt), .ww(ww)) u_alu (
		.clk(clk), .reset(reset),
		.in_valid(issue_fire && issue_unit == unit_alu),
		.alu_op(issue_alu_op), .warp(issue_warp), .rd(issue_rd),
		.mask(issue_mask), .pc(issue_pc), .a(issue_a), .b(issue_b),
		.out_wb(alu_wb), .out_mask(alu_mask), .out_rd(alu_rd),
		.out_warp(alu_warp), .out_pc(alu_pc), .out_data(alu_data)
	);

	csr_unit #(.nt(nt), .nw(nw)) u_csr (
		.clk(clk), .reset(reset),
		.in_valid(issue_fire && issue_unit == unit_csr),
		.csr_op(issue_csr_op), .warp(issue_warp), .rd(issue_rd),
		.mask(issue_mask), .a(issue_a),
		.out_wb(csr_wb), .out_mask(csr_mask), .out_rd(csr_rd),
		.out_warp(csr_warp), .out_data(csr_data)
	);

	load_unit #(.nt(nt), .nw(nw)) u_load (
		.clk(clk), .reset(reset),
		.in_valid(issue_fire && issue_unit == unit_load),
		.warp(issue_warp), .rd(issue_rd), .mask(issue_mask),
		.pc(issue_pc), .addr(issue_a), .busy(load_busy),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.prdata(prdata), .pready(pready),
		.out_wb(mem_wb), .out_mask(mem_mask), .out_rd(mem_rd),
		.out_warp(mem_warp), .out_pc(mem_pc), .out_data(mem_data),
		.mem_taken(mem_taken)
	);

	writeback_arbiter #(.nt(nt), .nw(nw)) u_arb (
		.clk(clk), .reset(reset),
		.alu_wb(alu_wb), .alu_mask(alu_mask), .alu_rd(alu_rd),
		.alu_warp(alu_warp), .alu_pc(alu_pc), .alu_data(alu_data),
		.csr_wb(csr_wb), .csr_mask(csr_mask), .csr_rd(csr_rd),
		.csr_warp(csr_warp), .csr_data(csr_data),
		.mem_wb(mem_wb), .mem_mask(mem_mask), .mem_rd(mem_rd),
		.mem_warp(mem_warp), .mem_pc(mem_pc), .mem_data(mem_data),
		.mem_taken(mem_taken),
		.wb_src(wb_src), .wb_mask(wb_mask), .wb_rd(wb_rd),
		.wb_warp(wb_warp), .wb_pc(wb_pc), .wb_data(wb_data)
	);

	warp_gpr #(.nt(nt), .nw(nw)) u_gpr (
		.clk(clk), .reset(reset),
		.wb_src(wb_src), .wb_mask(wb_mask), .wb_rd(wb_rd),
		.wb_warp(wb_warp), .wb_data(wb_data),
		.rd_warp(gpr_rd_warp), .rd_reg(gpr_rd_reg), .rd_data(gpr_rd_data)
	);

endmodule

`default_nettype wire

// File: verilog/warp_gpr.sv
`timescale 1ns/10ps
`default_nettype none

module warp_gpr import simt_pkg::*; #(
	parameter int nt = 4,
	parameter int nw = 4,
	localparam int ww = (nw > 1) ? $clog2(nw) : 1
) (
	input wire clk,
	input wire reset,
	input wire wb_src_t wb_src,
	input wire [nt-1:0] wb_mask,
	input wire [reg_w-1:0] wb_rd,
	input wire [ww-1:0] wb_warp,
	input wire [nt-1:0][data_w-1:0] wb_data,
	input wire [ww-1:0] rd_warp,
	input wire [reg_w-1:0] rd_reg,
	output logic [nt-1:0][data_w-1:0] rd_data
);

	logic [nt-1:0][data_w-1:0] regs [nw][reg_n];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int w = 0; w < nw; w++) begin
				for (int r = 0; r < reg_n; r++)
					regs[w][r] <= '0;
			end
		end else if (wb_src != wb_none) begin
			for (int i = 0; i < nt; i++) begin
				if (wb_mask[i])
					regs[wb_warp][wb_rd][i] <= wb_data[i];  // per lane write
			end
		end
	end

	assign rd_data = regs[rd_warp][rd_reg];

endmodule

`default_nettype wire

// File: verilog/writeback_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_arbiter import simt_pkg::*; #(
	parameter int nt = 4,
	parameter int nw = 4,
	localparam int ww = (nw > 1) ? $clog2(nw) : 1
) (
	input wire clk,
	input wire reset,
	input wire wb_src_t alu_wb,
	input wire [nt-1:0] alu_mask,
	input wire [reg_w-1:0] alu_rd,
	input wire [ww-1:0] alu_warp,
	input wire [data_w-1:0] alu_pc,
	input wire [nt-1:0][data_w-1:0] alu_data,
	input wire wb_src_t csr_wb,
	input wire [nt-1:0] csr_mask,
	input wire [reg_w-1:0] csr_rd,
	input wire [ww-1:0] csr_warp,
	input wire [nt-1:0][data_w-1:0] csr_data,
	input wire wb_src_t mem_wb,
	input wire [nt-1:0] mem_mask,
	input wire [reg_w-1:0] mem_rd,
	input wire [ww-1:0] mem_warp,
	input wire [data_w-1:0] mem_pc,
	input wire [nt-1:0][data_w-1:0] mem_data,
	output logic mem_taken,
	output wb_src_t wb_src,
	output logic [nt-1:0] wb_mask,
	output logic [reg_w-1:0] wb_rd,
	output logic [ww-1:0] wb_warp,
	output logic [data_w-1:0] wb_pc,
	output logic [nt-1:0][data_w-1:0] wb_data
);

	logic alu_present;
	logic csr_present;
	logic mem_present;
	wb_src_t sel_src;
	logic [nt-1:0] sel_mask;
	logic [reg_w-1:0] sel_rd;
	logic [ww-1:0] sel_warp;
	logic [data_w-1:0] sel_pc;
	logic [nt-1:0][data_w-1:0] sel_data;

	assign alu_present = (alu_wb != wb_none) && (|alu_mask);
	assign csr_present = (csr_wb != wb_none) && (|csr_mask);
	assign mem_present = (mem_wb != wb_none) && (|mem_mask);

	// load only gets the slot when nothing else wants it
	assign mem_taken = mem_present && !alu_present && !csr_present;

	always_comb begin
		sel_src = wb_none;
		sel_mask = '0;
		sel_rd = '0;
		sel_warp = '0;
		sel_pc = csr_pc_marker;
		sel_data = '0;
		if (alu_present) begin
			sel_src = alu_wb;
			sel_mask = alu_mask;
			sel_rd = alu_rd;
			sel_warp = alu_warp;
			sel_pc = alu_pc;
			sel_data = alu_data;
		end else if (csr_present) begin
			sel_src = csr_wb;
			sel_mask = csr_mask;
			sel_rd = csr_rd;
			sel_warp = csr_warp;
			sel_data = csr_data;
		end else if (mem_present) begin
			sel_src = mem_wb;
			sel_mask = mem_mask;
			sel_rd = mem_rd;
			sel_warp = mem_warp;
			sel_pc = mem_pc;
			sel_data = mem_data;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			wb_src <= wb_none;
		else
			wb_src <= sel_src;
	end

	always_ff @(posedge clk) begin
		wb_mask <= sel_mask;
		wb_rd <= sel_rd;
		wb_warp <= sel_warp;
		wb_pc <= sel_pc;
		wb_data <= sel_data;
	end

endmodule

`default_nettype wire

// File: verilog/load_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_unit import simt_pkg::*; #(
	parameter int nt = 4,
	parameter int nw = 4,
	localparam int ww = (nw > 1) ? $clog2(nw) : 1,
	localparam int lw = (nt > 1) ? $clog2(nt) : 1
) (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire [ww-1:0] warp,
	input wire [reg_w-1:0] rd,
	input wire [nt-1:0] mask,
	input wire [data_w-1:0] pc,
	input wire [nt-1:0][data_w-1:0] addr,
	output logic busy,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [data_w-1:0] paddr,
	input wire [data_w-1:0] prdata,
	input wire pready,
	output wb_src_t out_wb,
	output logic [nt-1:0] out_mask,
	output logic [reg_w-1:0] out_rd,
	output logic [ww-1:0] out_warp,
	output logic [data_w-1:0] out_pc,
	output logic [nt-1:0][data_w-1:0] out_data,
	input wire mem_taken
);

	typedef enum logic [1:0] {
		idle,
		setup,
		access,
		hold
	} state_t;

	state_t state;
	logic [nt-1:0] pending;  // lanes still to be read
	logic [lw-1:0] lane;
	logic [nt-1:0] lane_bit;
	logic present;

	logic [ww-1:0] warp_q;
	logic [reg_w-1:0] rd_q;
	logic [nt-1:0] mask_q;
	logic [data_w-1:0] pc_q;
	logic [nt-1:0][data_w-1:0] addr_q;
	logic [nt-1:0][data_w-1:0] data_q;

	// next lane to read is the lowest pending one
	always_comb begin
		lane = '0;
		for (int i = nt - 1; i >= 0; i--) begin
			if (pending[i])
				lane = lw'(i);
		end
	end

	assign lane_bit = nt'(1) << lane;
	assign present = (rd_q != '0) && (|mask_q);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= idle;
			pending <= '0;
		end else begin
			case (state)
				idle: if (in_valid) begin
					pending <= mask;
					state <= (|mask) ? setup : hold;
				end
				setup: state <= access;
				access: if (pready) begin
					pending <= pending & ~lane_bit;
					state <= (|(pending & ~lane_bit)) ? setup : hold;
				end
				hold: if (mem_taken || !present)
					state <= idle;  // nothing to write back when rd or mask is empty
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && in_valid) begin
			warp_q <= warp;
			rd_q <= rd;
			mask_q <= mask;
			pc_q <= pc;
			addr_q <= addr;
			data_q <= '0;
		end else if (state == access && pready) begin
			data_q[lane] <= prdata;
		end
	end

	assign busy = (state != idle);
	assign psel = (state == setup) || (state == access);
	assign penable = (state == access);
	assign pwrite = 1'b0;
	assign paddr = addr_q[lane];

	assign out_wb = (state == hold && rd_q != '0) ? wb_mem : wb_none;
	assign out_mask = mask_q;
	assign out_rd = rd_q;
	assign out_warp = warp_q;
	assign out_pc = pc_q;
	assign out_data = data_q;

endmodule

`default_nettype wire

// File: verilog/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit import simt_pkg::*; import isa_pkg::*; #(
	parameter int nt = 4,
	parameter int nw = 4,
	localparam int ww = (nw > 1) ? $clog2(nw) : 1
) (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire csr_op_t csr_op,
	input wire [ww-1:0] warp,
	input wire [reg_w-1:0] rd,
	input wire [nt-1:0] mask,
	input wire [nt-1:0][data_w-1:0] a,
	output wb_src_t out_wb,
	output logic [nt-1:0] out_mask,
	output logic [reg_w-1:0] out_rd,
	output logic [ww-1:0] out_warp,
	output logic [nt-1:0][data_w-1:0] out_data
);

	logic [data_w-1:0] scratch [nw];
	logic [data_w-1:0] swap_in;
	logic [nt-1:0][data_w-1:0] result;

	// the lowest active lane supplies the new scratch value
	always_comb begin
		swap_in = '0;
		for (int i = nt - 1; i >= 0; i--) begin
			if (mask[i])
				swap_in = a[i];
		end
	end

	always_comb begin
		for (int i = 0; i < nt; i++) begin
			if (csr_op == csr_read_id)
				result[i] = (data_w'(warp) << id_warp_shift) + data_w'(i);
			else
				result[i] = scratch[warp];  // old value comes back
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int w = 0; w < nw; w++)
				scratch[w] <= '0;
			out_wb <= wb_none;
		end else begin
			if (in_valid && csr_op == csr_swap_scratch && |mask)
				scratch[warp] <= swap_in;
			out_wb <= (in_valid && rd != '0) ? wb_csr : wb_none;
		end
	end

	always_ff @(posedge clk) begin
		out_mask <= mask;
		out_rd <= rd;
		out_warp <= warp;
		out_data <= result;
	end

endmodule

`default_nettype wire

// File: verilog/lane_alu.sv
`timescale 1ns/10ps
`default_nettype none

module lane_alu import simt_pkg::*; import isa_pkg::*; #(
	parameter int nt = 4,
	parameter int ww = 2
) (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire alu_op_t alu_op,
	input wire [ww-1:0] warp,
	input wire [reg_w-1:0] rd,
	input wire [nt-1:0] mask,
	input wire [data_w-1:0] pc,
	input wire [nt-1:0][data_w-1:0] a,
	input wire [nt-1:0][data_w-1:0] b,
	output wb_src_t out_wb,
	output logic [nt-1:0] out_mask,
	output logic [reg_w-1:0] out_rd,
	output logic [ww-1:0] out_warp,
	output logic [data_w-1:0] out_pc,
	output logic [nt-1:0][data_w-1:0] out_data
);

	logic [nt-1:0][data_w-1:0] result;

	always_comb begin
		for (int i = 0; i < nt; i++) begin
			case (alu_op)
				op_add: result[i] = a[i] + b[i];
				op_sub: result[i] = a[i] - b[i];
				op_and: result[i] = a[i] & b[i];
				op_or: result[i] = a[i] | b[i];
				op_xor: result[i] = a[i] ^ b[i];
				op_sll: result[i] = a[i] << b[i][4:0];  // shift amount from low bits only
				op_slt: result[i] = {{(data_w - 1){1'b0}}, $signed(a[i]) < $signed(b[i])};
				default: result[i] = '0;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_wb <= wb_none;
		end else begin
			out_wb <= (in_valid && rd != '0) ? wb_alu : wb_none;  // rd 0 is dropped
		end
	end

	always_ff @(posedge clk) begin
		out_mask <= mask;
		out_rd <= rd;
		out_warp <= warp;
		out_pc <= pc;
		out_data <= result;
	end

endmodule

`default_nettype wire

// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef enum logic [1:0] {
		unit_alu  = 2'd0,
		unit_csr  = 2'd1,
		unit_load = 2'd2
	} unit_t;

	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		op_sll = 3'd5,
		op_slt = 3'd6  // signed compare
	} alu_op_t;

	typedef enum logic {
		csr_swap_scratch = 1'b0,
		csr_read_id      = 1'b1
	} csr_op_t;

endpackage

`default_nettype wire

// File: verilog/simt_pkg.sv
`default_nettype none

package simt_pkg;

	// register index and lane word widths
	localparam int reg_w = 5;
	localparam int data_w = 32;

	// number of registers per warp
	localparam int reg_n = 1 << reg_w;

	// read-id packs the warp number above the lane index
	localparam int id_warp_shift = 8;

	// pc carried by csr writebacks
	localparam logic [data_w-1:0] csr_pc_marker = 32'hdeadbeef;

	// which unit produced a writeback
	typedef enum logic [1:0] {
		wb_none = 2'd0,
		wb_alu  = 2'd1,
		wb_csr  = 2'd2,
		wb_mem  = 2'd3
	} wb_src_t;

endpackage

`default_nettype wire
